// ==== flist.f ====
src/cpu_types_pkg.sv
src/instr_dispatch.sv
src/control_unit.sv
src/decode_collect.sv
src/decode_array.sv
verif/decode_checker.sv
verif/decode_array_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decode array testbench with Verilator.
set -u

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module decode_array_tb \
	-f flist.f --Mdir obj_dir -o sim_decode > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/sim_decode > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -qx "TB PASSED" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// ==== verif/decode_array_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_array_tb;

	localparam int n_stream = 200;
	localparam int n_random = 2000;
	// sweeps send two words per code, back-pressure fills the lanes twice
	localparam int total_words = 2 * 15 + 2 * 13 + n_stream + 2 * cpu_types_pkg::num_lanes
	                             + n_random;
	localparam int timeout_cycles = total_words * 20;

	logic         clk;
	logic         reset;
	logic         in_valid;
	logic [31:0]  in_instr;
	logic         in_ready;
	logic         out_valid;
	logic         out_ready;
	logic         reg_write;
	logic         mem_read;
	logic         mem_write;
	logic         alu_src_imm;
	logic         reg_dest_rt;
	logic         halt;
	logic [3:0]   alu_op;
	logic [4:0]   dest_reg;
	logic [31:0]  imm32;
	logic [127:0] test_name;
	int           error_count;
	int           pending;
	int           tb_errors;
	int           total;
	logic [31:0]  lfsr;
	// directed words go out before any random ones
	logic [31:0]  dir_q[$];

	decode_array dut_i (
		.clk         (clk),
		.reset       (reset),
		.in_valid    (in_valid),
		.in_instr    (in_instr),
		.in_ready    (in_ready),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.reg_write   (reg_write),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.alu_src_imm (alu_src_imm),
		.reg_dest_rt (reg_dest_rt),
		.halt        (halt),
		.alu_op      (alu_op),
		.dest_reg    (dest_reg),
		.imm32       (imm32)
	);

	decode_checker check_i (
		.clk         (clk),
		.reset       (reset),
		.test_name   (test_name),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_instr    (in_instr),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.reg_write   (reg_write),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.alu_src_imm (alu_src_imm),
		.reg_dest_rt (reg_dest_rt),
		.halt        (halt),
		.alu_op      (alu_op),
		.dest_reg    (dest_reg),
		.imm32       (imm32),
		.error_count (error_count),
		.pending     (pending)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic cpu_types_pkg::opcode_t pick_opcode(input int idx);
		case (idx)
			0:       return cpu_types_pkg::RTYPE;
			1:       return cpu_types_pkg::J;
			2:       return cpu_types_pkg::BEQ;
			3:       return cpu_types_pkg::BNE;
			4:       return cpu_types_pkg::ADDI;
			5:       return cpu_types_pkg::ADDIU;
			6:       return cpu_types_pkg::SLTI;
			7:       return cpu_types_pkg::SLTIU;
			8:       return cpu_types_pkg::ANDI;
			9:       return cpu_types_pkg::ORI;
			10:      return cpu_types_pkg::XORI;
			11:      return cpu_types_pkg::LUI;
			12:      return cpu_types_pkg::LW;
			13:      return cpu_types_pkg::SW;
			default: return cpu_types_pkg::HALT;
		endcase
	endfunction

	function automatic cpu_types_pkg::funct_t pick_funct(input int idx);
		case (idx)
			0:       return cpu_types_pkg::SLLV;
			1:       return cpu_types_pkg::SRLV;
			2:       return cpu_types_pkg::JR;
			3:       return cpu_types_pkg::ADD;
			4:       return cpu_types_pkg::ADDU;
			5:       return cpu_types_pkg::SUB;
			6:       return cpu_types_pkg::SUBU;
			7:       return cpu_types_pkg::AND;
			8:       return cpu_types_pkg::OR;
			9:       return cpu_types_pkg::XOR;
			10:      return cpu_types_pkg::NOR;
			11:      return cpu_types_pkg::SLT;
			default: return cpu_types_pkg::SLTU;
		endcase
	endfunction

	// register fields random, top sets bit 15 of the immediate
	function automatic logic [31:0] build_word(input cpu_types_pkg::opcode_t op,
	                                           input cpu_types_pkg::funct_t fn,
	                                           input logic top);
		cpu_types_pkg::instr_u w;
		logic [31:0]           r;
		r = rand_bits(25);
		if (op == cpu_types_pkg::RTYPE) begin
			w.r.opcode = op;
			w.r.rs     = r[4:0];
			w.r.rt     = r[9:5];
			w.r.rd     = r[14:10];
			w.r.shamt  = r[19:15];
			w.r.funct  = fn;
		end else begin
			w.i.opcode = op;
			w.i.rs     = r[4:0];
			w.i.rt     = r[9:5];
			w.i.imm    = {top, r[24:10]};
		end
		return w;
	endfunction

	function automatic logic [31:0] next_word();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		if (dir_q.size() != 0) begin
			return dir_q.pop_front();
		end
		a = rand_bits(4);
		b = rand_bits(4);
		c = rand_bits(1);
		return build_word(pick_opcode(int'(a % 32'd15)), pick_funct(int'(b % 32'd13)), c[0]);
	endfunction

	// out_mode 0 keeps out_ready high, 1 keeps it low, 2 toggles it randomly
	task automatic run_stream(input int n, input logic in_gaps, input int out_mode);
		int   sent;
		logic acc;
		sent = 0;
		while (sent < n) begin
			if (!in_valid) begin
				if (!in_gaps || rand_bits(2) != 0) begin
					in_instr = next_word();
					in_valid = 1'b1;
				end
			end
			case (out_mode)
				0:       out_ready = 1'b1;
				1:       out_ready = 1'b0;
				default: out_ready = (rand_bits(2) != 0);
			endcase
			// mid-cycle the handshake for the coming edge is settled
			@(negedge clk);
			acc = in_valid && in_ready;
			@(posedge clk);
			#1;
			if (acc) begin
				in_valid = 1'b0;
				sent++;
			end
		end
	endtask

	// empty the lanes and make sure nothing stays behind
	task automatic drain();
		int cycles;
		cycles    = 0;
		in_valid  = 1'b0;
		out_ready = 1'b1;
		while (pending != 0 && cycles < 50) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (pending != 0) begin
			$display("%0d accepted words never came out during %0s", pending, test_name);
			tb_errors++;
		end
	endtask

	initial begin
		reset     = 1'b1;
		in_valid  = 1'b0;
		in_instr  = '0;
		out_ready = 1'b0;
		tb_errors = 0;
		lfsr      = 32'h08f5b43b;
		test_name = "reset";
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		// one idle cycle so the checker sees the state right after reset
		@(posedge clk);
		#1;

		test_name = "opcode_sweep";
		for (int i = 0; i < 15; i++) begin
			dir_q.push_back(build_word(pick_opcode(i), cpu_types_pkg::ADD, 1'b0));
			dir_q.push_back(build_word(pick_opcode(i), cpu_types_pkg::ADD, 1'b1));
		end
		run_stream(30, 1'b0, 0);
		drain();

		test_name = "funct_sweep";
		for (int i = 0; i < 13; i++) begin
			dir_q.push_back(build_word(cpu_types_pkg::RTYPE, pick_funct(i), 1'b0));
			dir_q.push_back(build_word(cpu_types_pkg::RTYPE, pick_funct(i), 1'b1));
		end
		run_stream(26, 1'b0, 0);
		drain();

		test_name = "stream";
		run_stream(n_stream, 1'b0, 0);
		drain();

		// fill every lane, then offer one more word while the output is stalled
		test_name = "backpressure";
		run_stream(cpu_types_pkg::num_lanes, 1'b0, 1);
		in_instr  = next_word();
		in_valid  = 1'b1;
		out_ready = 1'b0;
		repeat (6) @(posedge clk);
		#1;
		run_stream(cpu_types_pkg::num_lanes, 1'b0, 0);
		drain();

		test_name = "random_gaps";
		run_stream(n_random, 1'b1, 2);
		drain();

		total = error_count + tb_errors;
		$display("checks done with %0d errors", total);
		if (total == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// bound on the whole run
	initial begin
		repeat (timeout_cycles) @(posedge clk);
		$display("run did not finish within %0d cycles", timeout_cycles);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/decode_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_checker (
	input  logic           clk,
	input  logic           reset,
	input  logic [127:0]   test_name,
	input  logic           in_valid,
	input  logic           in_ready,
	input  logic [31:0]    in_instr,
	input  logic           out_valid,
	input  logic           out_ready,
	input  logic           reg_write,
	input  logic           mem_read,
	input  logic           mem_write,
	input  logic           alu_src_imm,
	input  logic           reg_dest_rt,
	input  logic           halt,
	input  logic [3:0]     alu_op,
	input  logic [4:0]     dest_reg,
	input  logic [31:0]    imm32,
	output int             error_count,
	output int             pending
);

	// accepted words still waiting for their control word
	logic [31:0] exp_q[$];
	logic [31:0] word;
	logic [46:0] exp_w;
	logic [46:0] act_w;
	int          errors = 0;
	int          in_flight = 0;

	assign error_count = errors;
	assign pending     = in_flight;

	// observed control word in one vector
	assign act_w = {reg_write, mem_read, mem_write, alu_src_imm, reg_dest_rt, halt,
	                alu_op, dest_reg, imm32};

	// control word as the decode rules define it in the packing of act_w
	function automatic logic [46:0] expected_word(input logic [31:0] w);
		logic [5:0]  op;
		logic [5:0]  fn;
		logic        rw;
		logic        src;
		logic        drt;
		logic        sext;
		logic [3:0]  alu;
		logic [4:0]  dst;
		logic [31:0] ext;
		op   = w[31:26];
		fn   = w[5:0];
		rw   = !(op inside {cpu_types_pkg::J, cpu_types_pkg::SW, cpu_types_pkg::BEQ,
		                    cpu_types_pkg::BNE, cpu_types_pkg::HALT}) &&
		       !(op == cpu_types_pkg::RTYPE && fn == cpu_types_pkg::JR);
		sext = op inside {cpu_types_pkg::ADDI, cpu_types_pkg::ADDIU, cpu_types_pkg::LW,
		                  cpu_types_pkg::SW, cpu_types_pkg::BEQ, cpu_types_pkg::BNE,
		                  cpu_types_pkg::SLTI, cpu_types_pkg::SLTIU};
		src  = op inside {cpu_types_pkg::ADDI, cpu_types_pkg::ADDIU, cpu_types_pkg::ANDI,
		                  cpu_types_pkg::ORI, cpu_types_pkg::XORI, cpu_types_pkg::SLTI,
		                  cpu_types_pkg::SLTIU, cpu_types_pkg::LW, cpu_types_pkg::SW,
		                  cpu_types_pkg::LUI};
		drt  = src && (op != cpu_types_pkg::SW);
		// rt sits in bits 20:16 and rd in bits 15:11
		dst  = drt ? w[20:16] : w[15:11];
		ext  = sext ? {{16{w[15]}}, w[15:0]} : {16'h0000, w[15:0]};
		alu  = cpu_types_pkg::ALU_ADD;
		if (op == cpu_types_pkg::RTYPE) begin
			case (fn)
				cpu_types_pkg::SLLV: alu = cpu_types_pkg::ALU_SLL;
				cpu_types_pkg::SRLV: alu = cpu_types_pkg::ALU_SRL;
				cpu_types_pkg::SUB,
				cpu_types_pkg::SUBU: alu = cpu_types_pkg::ALU_SUB;
				cpu_types_pkg::AND:  alu = cpu_types_pkg::ALU_AND;
				cpu_types_pkg::OR:   alu = cpu_types_pkg::ALU_OR;
				cpu_types_pkg::XOR:  alu = cpu_types_pkg::ALU_XOR;
				cpu_types_pkg::NOR:  alu = cpu_types_pkg::ALU_NOR;
				cpu_types_pkg::SLT:  alu = cpu_types_pkg::ALU_SLT;
				cpu_types_pkg::SLTU: alu = cpu_types_pkg::ALU_SLTU;
				default:             alu = cpu_types_pkg::ALU_ADD;
			endcase
		end else begin
			case (op)
				cpu_types_pkg::BEQ,
				cpu_types_pkg::BNE:   alu = cpu_types_pkg::ALU_SUB;
				cpu_types_pkg::SLTI:  alu = cpu_types_pkg::ALU_SLT;
				cpu_types_pkg::SLTIU: alu = cpu_types_pkg::ALU_SLTU;
				cpu_types_pkg::ANDI:  alu = cpu_types_pkg::ALU_AND;
				cpu_types_pkg::ORI:   alu = cpu_types_pkg::ALU_OR;
				cpu_types_pkg::XORI:  alu = cpu_types_pkg::ALU_XOR;
				cpu_types_pkg::LUI:   alu = cpu_types_pkg::ALU_LUI;
				default:              alu = cpu_types_pkg::ALU_ADD;
			endcase
		end
		return {rw, (op == cpu_types_pkg::LW), (op == cpu_types_pkg::SW), src, drt,
		        (op == cpu_types_pkg::HALT), alu, dst, ext};
	endfunction

	// everything is sampled at the edge before the DUT registers move
	always @(posedge clk) begin
		if (reset) begin
			exp_q.delete();
		end else begin
			// handshakes must track the number of words in flight
			if (out_valid !== (exp_q.size() != 0)) begin
				$display("out_valid is %b with %0d words in flight during %0s",
				         out_valid, exp_q.size(), test_name);
				errors++;
			end
			if (in_ready !== (exp_q.size() < cpu_types_pkg::num_lanes)) begin
				$display("in_ready is %b with %0d words in flight during %0s",
				         in_ready, exp_q.size(), test_name);
				errors++;
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					$display("a control word came out with no word accepted during %0s",
					         test_name);
					errors++;
				end else begin
					word  = exp_q.pop_front();
					exp_w = expected_word(word);
					if (act_w !== exp_w) begin
						$display("** Error %0s: instr %08h expected %012h actual %012h",
						         test_name, word, exp_w, act_w);
						errors++;
					end
				end
			end
			// a word accepted now cannot leave before the next edge
			if (in_valid && in_ready) begin
				exp_q.push_back(in_instr);
			end
		end
		in_flight = exp_q.size();
	end

endmodule

`default_nettype wire

// ==== src/decode_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_array (
	input  logic        clk,
	input  logic        reset,
	input  logic        in_valid,
	input  logic [31:0] in_instr,
	output logic        in_ready,
	output logic        out_valid,
	input  logic        out_ready,
	output logic        reg_write,
	output logic        mem_read,
	output logic        mem_write,
	output logic        alu_src_imm,
	output logic        reg_dest_rt,
	output logic        halt,
	output logic [3:0]  alu_op,
	output logic [4:0]  dest_reg,
	output logic [31:0] imm32
);

	// dispatcher to lanes
	logic [cpu_types_pkg::num_lanes-1:0]       lane_valid;
	logic [cpu_types_pkg::num_lanes-1:0]       lane_ready;
	logic [31:0]                               lane_instr;

	// lanes to collector
	logic [cpu_types_pkg::num_lanes-1:0]       busy;
	logic [cpu_types_pkg::num_lanes-1:0]       take;
	logic [cpu_types_pkg::num_lanes-1:0]       lane_reg_write;
	logic [cpu_types_pkg::num_lanes-1:0]       lane_mem_read;
	logic [cpu_types_pkg::num_lanes-1:0]       lane_mem_write;
	logic [cpu_types_pkg::num_lanes-1:0]       lane_alu_src_imm;
	logic [cpu_types_pkg::num_lanes-1:0]       lane_reg_dest_rt;
	logic [cpu_types_pkg::num_lanes-1:0]       lane_halt;
	logic [cpu_types_pkg::num_lanes-1:0][3:0]  lane_alu_op;
	logic [cpu_types_pkg::num_lanes-1:0][4:0]  lane_dest_reg;
	logic [cpu_types_pkg::num_lanes-1:0][31:0] lane_imm32;

	instr_dispatch dispatch_i (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_instr   (in_instr),
		.lane_ready (lane_ready),
		.in_ready   (in_ready),
		.lane_valid (lane_valid),
		.lane_instr (lane_instr)
	);

	// one decode lane per in-flight word
	for (genvar g = 0; g < cpu_types_pkg::num_lanes; g++) begin : g_lane
		control_unit lane_i (
			.clk         (clk),
			.reset       (reset),
			.load        (lane_valid[g]),
			.instr       (lane_instr),
			.take        (take[g]),
			.ready       (lane_ready[g]),
			.busy        (busy[g]),
			.reg_write   (lane_reg_write[g]),
			.mem_read    (lane_mem_read[g]),
			.mem_write   (lane_mem_write[g]),
			.alu_src_imm (lane_alu_src_imm[g]),
			.reg_dest_rt (lane_reg_dest_rt[g]),
			.halt        (lane_halt[g]),
			.alu_op      (lane_alu_op[g]),
			.dest_reg    (lane_dest_reg[g]),
			.imm32       (lane_imm32[g])
		);
	end

	decode_collect collect_i (
		.clk              (clk),
		.reset            (reset),
		.out_ready        (out_ready),
		.busy             (busy),
		.lane_reg_write   (lane_reg_write),
		.lane_mem_read    (lane_mem_read),
		.lane_mem_write   (lane_mem_write),
		.lane_alu_src_imm (lane_alu_src_imm),
		.lane_reg_dest_rt (lane_reg_dest_rt),
		.lane_halt        (lane_halt),
		.lane_alu_op      (lane_alu_op),
		.lane_dest_reg    (lane_dest_reg),
		.lane_imm32       (lane_imm32),
		.take             (take),
		.out_valid        (out_valid),
		.reg_write        (reg_write),
		.mem_read         (mem_read),
		.mem_write        (mem_write),
		.alu_src_imm      (alu_src_imm),
		.reg_dest_rt      (reg_dest_rt),
		.halt             (halt),
		.alu_op           (alu_op),
		.dest_reg         (dest_reg),
		.imm32            (imm32)
	);

endmodule

`default_nettype wire

// ==== src/decode_collect.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_collect (
	input  logic                                           clk,
	input  logic                                           reset,
	input  logic                                           out_ready,
	input  logic [cpu_types_pkg::num_lanes-1:0]            busy,
	input  logic [cpu_types_pkg::num_lanes-1:0]            lane_reg_write,
	input  logic [cpu_types_pkg::num_lanes-1:0]            lane_mem_read,
	input  logic [cpu_types_pkg::num_lanes-1:0]            lane_mem_write,
	input  logic [cpu_types_pkg::num_lanes-1:0]            lane_alu_src_imm,
	input  logic [cpu_types_pkg::num_lanes-1:0]            lane_reg_dest_rt,
	input  logic [cpu_types_pkg::num_lanes-1:0]            lane_halt,
	input  logic [cpu_types_pkg::num_lanes-1:0][3:0]       lane_alu_op,
	input  logic [cpu_types_pkg::num_lanes-1:0][4:0]       lane_dest_reg,
	input  logic [cpu_types_pkg::num_lanes-1:0][31:0]      lane_imm32,
	output logic [cpu_types_pkg::num_lanes-1:0]            take,
	output logic                                           out_valid,
	output logic                                           reg_write,
	output logic                                           mem_read,
	output logic                                           mem_write,
	output logic                                           alu_src_imm,
	output logic                                           reg_dest_rt,
	output logic                                           halt,
	output logic [3:0]                                     alu_op,
	output logic [4:0]                                     dest_reg,
	output logic [31:0]                                    imm32
);

	// lane holding the oldest word
	logic [cpu_types_pkg::lane_bits-1:0] rd_ptr;
	logic                                xfer;

	// output follows the pointed lane
	assign out_valid   = busy[rd_ptr];
	assign reg_write   = lane_reg_write[rd_ptr];
	assign mem_read    = lane_mem_read[rd_ptr];
	assign mem_write   = lane_mem_write[rd_ptr];
	assign alu_src_imm = lane_alu_src_imm[rd_ptr];
	assign reg_dest_rt = lane_reg_dest_rt[rd_ptr];
	assign halt        = lane_halt[rd_ptr];
	assign alu_op      = lane_alu_op[rd_ptr];
	assign dest_reg    = lane_dest_reg[rd_ptr];
	assign imm32       = lane_imm32[rd_ptr];

	assign xfer = out_valid && out_ready;

	// release the drained lane
	always_comb begin
		take         = '0;
		take[rd_ptr] = xfer;
	end

	// read pointer trails the write pointer in the same order
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
		end else if (xfer) begin
			if (rd_ptr == cpu_types_pkg::lane_bits'(cpu_types_pkg::num_lanes - 1)) begin
				rd_ptr <= '0;
			end else begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input  logic        clk,
	input  logic        reset,
	input  logic        load,
	input  logic [31:0] instr,
	input  logic        take,
	output logic        ready,
	output logic        busy,
	output logic        reg_write,
	output logic        mem_read,
	output logic        mem_write,
	output logic        alu_src_imm,
	output logic        reg_dest_rt,
	output logic        halt,
	output logic [3:0]  alu_op,
	output logic [4:0]  dest_reg,
	output logic [31:0] imm32
);

	// incoming word in both formats
	cpu_types_pkg::instr_u instr_v;

	// decoded control word before the output register
	logic                  reg_write_d;
	logic                  mem_read_d;
	logic                  mem_write_d;
	logic                  alu_src_imm_d;
	logic                  reg_dest_rt_d;
	logic                  halt_d;
	cpu_types_pkg::aluop_t alu_op_d;
	logic [4:0]            dest_reg_d;
	logic [31:0]           imm32_d;
	// sign rather than zero extension of the immediate
	logic                  sign_ext;

	assign instr_v = instr;

	// memory enables and halt
	assign mem_write_d = (instr_v.i.opcode == cpu_types_pkg::SW);
	assign mem_read_d  = (instr_v.i.opcode == cpu_types_pkg::LW);
	assign halt_d      = (instr_v.i.opcode == cpu_types_pkg::HALT);

	// flag decode from the opcode
	always_comb begin
		// defaults give a register format alu instruction
		reg_write_d   = 1'b1;
		sign_ext      = 1'b0;
		alu_src_imm_d = 1'b0;
		reg_dest_rt_d = 1'b0;
		case (instr_v.i.opcode)
			cpu_types_pkg::RTYPE: begin
				// jump register writes nothing back
				reg_write_d = (instr_v.r.funct != cpu_types_pkg::JR);
			end
			cpu_types_pkg::J,
			cpu_types_pkg::HALT: begin
				reg_write_d = 1'b0;
			end
			cpu_types_pkg::BEQ,
			cpu_types_pkg::BNE: begin
				reg_write_d = 1'b0;
				sign_ext    = 1'b1;
			end
			cpu_types_pkg::SW: begin
				// store uses the immediate as offset but has no destination
				reg_write_d   = 1'b0;
				sign_ext      = 1'b1;
				alu_src_imm_d = 1'b1;
			end
			cpu_types_pkg::ADDI,
			cpu_types_pkg::ADDIU,
			cpu_types_pkg::SLTI,
			cpu_types_pkg::SLTIU,
			cpu_types_pkg::LW: begin
				sign_ext      = 1'b1;
				alu_src_imm_d = 1'b1;
				reg_dest_rt_d = 1'b1;
			end
			cpu_types_pkg::ANDI,
			cpu_types_pkg::ORI,
			cpu_types_pkg::XORI,
			cpu_types_pkg::LUI: begin
				// logical immediates are zero extended
				alu_src_imm_d = 1'b1;
				reg_dest_rt_d = 1'b1;
			end
			default: begin
				reg_write_d = 1'b1;
			end
		endcase
	end

	// alu operation select
	always_comb begin
		alu_op_d = cpu_types_pkg::ALU_ADD;
		if (instr_v.r.opcode == cpu_types_pkg::RTYPE) begin
			// register format takes the operation from funct
			case (instr_v.r.funct)
				cpu_types_pkg::SLLV: alu_op_d = cpu_types_pkg::ALU_SLL;
				cpu_types_pkg::SRLV: alu_op_d = cpu_types_pkg::ALU_SRL;
				cpu_types_pkg::ADD,
				cpu_types_pkg::ADDU: alu_op_d = cpu_types_pkg::ALU_ADD;
				cpu_types_pkg::SUB,
				cpu_types_pkg::SUBU: alu_op_d = cpu_types_pkg::ALU_SUB;
				cpu_types_pkg::AND:  alu_op_d = cpu_types_pkg::ALU_AND;
				cpu_types_pkg::OR:   alu_op_d = cpu_types_pkg::ALU_OR;
				cpu_types_pkg::XOR:  alu_op_d = cpu_types_pkg::ALU_XOR;
				cpu_types_pkg::NOR:  alu_op_d = cpu_types_pkg::ALU_NOR;
				cpu_types_pkg::SLT:  alu_op_d = cpu_types_pkg::ALU_SLT;
				cpu_types_pkg::SLTU: alu_op_d = cpu_types_pkg::ALU_SLTU;
				default:             alu_op_d = cpu_types_pkg::ALU_ADD;
			endcase
		end else begin
			case (instr_v.i.opcode)
				// branches compare by subtraction
				cpu_types_pkg::BEQ,
				cpu_types_pkg::BNE:   alu_op_d = cpu_types_pkg::ALU_SUB;
				cpu_types_pkg::SLTI:  alu_op_d = cpu_types_pkg::ALU_SLT;
				cpu_types_pkg::SLTIU: alu_op_d = cpu_types_pkg::ALU_SLTU;
				cpu_types_pkg::ANDI:  alu_op_d = cpu_types_pkg::ALU_AND;
				cpu_types_pkg::ORI:   alu_op_d = cpu_types_pkg::ALU_OR;
				cpu_types_pkg::XORI:  alu_op_d = cpu_types_pkg::ALU_XOR;
				cpu_types_pkg::LUI:   alu_op_d = cpu_types_pkg::ALU_LUI;
				// address add for loads and stores, plain add for addi
				default:              alu_op_d = cpu_types_pkg::ALU_ADD;
			endcase
		end
	end

	// destination is rt for immediate formats
	assign dest_reg_d = reg_dest_rt_d ? instr_v.i.rt : instr_v.r.rd;

	// extended immediate
	assign imm32_d = sign_ext ? {{16{instr_v.i.imm[15]}}, instr_v.i.imm}
	                          : {16'h0000, instr_v.i.imm};

	// lane occupancy
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (load) begin
			// a load in the drain cycle keeps the lane full
			busy <= 1'b1;
		end else if (take) begin
			busy <= 1'b0;
		end
	end

	assign ready = ~busy;

	// control word register held until drained
	always_ff @(posedge clk) begin
		if (load) begin
			reg_write   <= reg_write_d;
			mem_read    <= mem_read_d;
			mem_write   <= mem_write_d;
			alu_src_imm <= alu_src_imm_d;
			reg_dest_rt <= reg_dest_rt_d;
			halt        <= halt_d;
			alu_op      <= alu_op_d;
			dest_reg    <= dest_reg_d;
			imm32       <= imm32_d;
		end
	end

endmodule

`default_nettype wire

// ==== src/instr_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_dispatch (
	input  logic                                    clk,
	input  logic                                    reset,
	input  logic                                    in_valid,
	input  logic [31:0]                             in_instr,
	input  logic [cpu_types_pkg::num_lanes-1:0]     lane_ready,
	output logic                                    in_ready,
	output logic [cpu_types_pkg::num_lanes-1:0]     lane_valid,
	output logic [31:0]                             lane_instr
);

	// next lane to receive a word
	logic [cpu_types_pkg::lane_bits-1:0] wr_ptr;
	// word accepted this cycle
	logic                                xfer;

	// only the pointed lane may take the word
	assign in_ready = lane_ready[wr_ptr];
	assign xfer     = in_valid && in_ready;

	// all lanes see the same word on a shared bus
	assign lane_instr = in_instr;

	// one-hot load strobe for the pointed lane
	always_comb begin
		lane_valid         = '0;
		lane_valid[wr_ptr] = xfer;
	end

	// round robin write pointer
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
		end else if (xfer) begin
			// wrap after the last lane
			if (wr_ptr == cpu_types_pkg::lane_bits'(cpu_types_pkg::num_lanes - 1)) begin
				wr_ptr <= '0;
			end else begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/cpu_types_pkg.sv ====
`default_nettype none

package cpu_types_pkg;

	// number of decode lanes and so the number of words in flight
	localparam int num_lanes = 4;

	// width of a lane index
	localparam int lane_bits = $clog2(num_lanes);

	// primary opcode field in bits 31 to 26
	typedef enum logic [5:0] {
		RTYPE = 6'b000000,
		J     = 6'b000010,
		BEQ   = 6'b000100,
		BNE   = 6'b000101,
		ADDI  = 6'b001000,
		ADDIU = 6'b001001,
		SLTI  = 6'b001010,
		SLTIU = 6'b001011,
		ANDI  = 6'b001100,
		ORI   = 6'b001101,
		XORI  = 6'b001110,
		LUI   = 6'b001111,
		LW    = 6'b100011,
		SW    = 6'b101011,
		HALT  = 6'b111111
	} opcode_t;

	// function field of register format words
	typedef enum logic [5:0] {
		SLLV = 6'b000100,
		SRLV = 6'b000110,
		JR   = 6'b001000,
		ADD  = 6'b100000,
		ADDU = 6'b100001,
		SUB  = 6'b100010,
		SUBU = 6'b100011,
		AND  = 6'b100100,
		OR   = 6'b100101,
		XOR  = 6'b100110,
		NOR  = 6'b100111,
		SLT  = 6'b101010,
		SLTU = 6'b101011
	} funct_t;

	// operation code handed to the alu
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_NOR  = 4'd5,
		ALU_SLT  = 4'd6,
		ALU_SLTU = 4'd7,
		ALU_SLL  = 4'd8,
		ALU_SRL  = 4'd9,
		// upper immediate load goes through the alu as well
		ALU_LUI  = 4'd10
	} aluop_t;

	// one instruction word seen either as register or immediate format
	typedef union packed {
		// register format
		struct packed {
			opcode_t    opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			funct_t     funct;
		} r;
		// immediate format
		struct packed {
			opcode_t     opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i;
	} instr_u;

endpackage

`default_nettype wire
